//--- hw/rom_ctrl_macros.svh
`ifndef ROM_CTRL_MACROS_SVH
`define ROM_CTRL_MACROS_SVH

// Host side widths
`define ROM_DATA_W          16      // Data word and host bus
`define ROM_BANK_W          4       // 16 banks of 128 KB
`define ROM_OFFSET_W        4       // Register offset field

// Register map
`define ROM_REG_ADDR        4'h0    // Word address, write starts a read
`define ROM_REG_BANK        4'h1    // Bank number
`define ROM_REG_DATA        4'h2    // Last word read
`define ROM_REG_STATUS      4'h3    // Bit 0 is valid

// Flash addressing
`define QSPI_ADDR_W         24      // Byte address on the wire
`define QSPI_BANK_BASE      7'h10   // 2 MB boundary in 128 KB units

// Fast Read Quad I/O
`define QSPI_CMD_QUAD_READ  8'hEB
`define QSPI_MODE_BYTE      8'hF0   // No continuous read

// Phase lengths in SPI cycles
`define QSPI_CMD_CYCLES     8       // One bit per cycle on DQ0
`define QSPI_ADDR_CYCLES    6       // One nibble per cycle
`define QSPI_MODE_CYCLES    2
`define QSPI_DUMMY_CYCLES   4
`define QSPI_DATA_NIBBLES   4       // One 16-bit word

`endif

//--- hw/rom_ctrl_pkg.sv
`include "rom_ctrl_macros.svh"

package rom_ctrl_pkg;

    // Sequencer phases, one per part of the flash transaction
    typedef enum logic [4:0] {
        ST_IDLE,                    // cs_n high, waiting for a request
        ST_CMD,                     // Command byte on DQ0
        ST_ADDR,                    // Six address nibbles
        ST_MODE,                    // Two mode nibbles
        ST_DUMMY,                   // Bus turned around
        ST_READ,                    // Data nibbles 1 to 3
        ST_DONE                     // cs_n high again for one SPI cycle
    } seq_state_t;

    // Host register offsets
    typedef enum logic [`ROM_OFFSET_W-1:0] {
        REG_ADDR   = `ROM_REG_ADDR,
        REG_BANK   = `ROM_REG_BANK,
        REG_DATA   = `ROM_REG_DATA,
        REG_STATUS = `ROM_REG_STATUS
    } reg_offset_t;

    // One host access, strobes are single cycle
    typedef struct packed {
        logic                     select;
        logic                     read;
        logic                     write;
        logic [`ROM_OFFSET_W-1:0] offset;   // May hold unmapped values
        logic [`ROM_DATA_W-1:0]   wdata;
    } host_bus_t;

    // Read request from the register block
    typedef struct packed {
        logic                    pending;   // Held until accepted
        logic [`QSPI_ADDR_W-1:0] addr;      // Flash byte address
    } read_req_t;

    // Sequencer view handed to the datapath
    typedef struct packed {
        logic       step;                   // SPI clock enable
        seq_state_t state;                  // Current phase
        logic [2:0] index;                  // Bit or nibble within the phase
    } seq_step_t;

endpackage

//--- hw/rom_regs.sv
`include "rom_ctrl_macros.svh"

module rom_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  rom_ctrl_pkg::host_bus_t host,
    output logic [`ROM_DATA_W-1:0]  rdata,
    output rom_ctrl_pkg::read_req_t req,
    input  logic                    accept,      // Sequencer took the request
    input  logic                    done_pulse,  // Word captured
    input  logic [`ROM_DATA_W-1:0]  data_word
);

    import rom_ctrl_pkg::*;

    // Bank field of the byte address sits above the word address and the zero bit
    localparam int PAGE_W = `QSPI_ADDR_W - `ROM_DATA_W - 1;

    logic [`ROM_BANK_W-1:0] bank_reg;
    logic [`ROM_DATA_W-1:0] word_addr;
    logic                   pending;
    logic                   valid;
    logic                   wr_addr;
    logic                   wr_bank;
    logic                   rd_en;
    logic [PAGE_W-1:0]      page;

    // Access decode
    assign wr_addr = host.select && host.write && (host.offset == REG_ADDR);
    assign wr_bank = host.select && host.write && (host.offset == REG_BANK);
    assign rd_en   = host.select && host.read;

    // Bank and word address registers
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_reg  <= '0;
            word_addr <= '0;
        end else begin
            if (wr_bank) begin
                bank_reg <= host.wdata[`ROM_BANK_W-1:0];  // Upper bits ignored
            end
            if (wr_addr) begin
                word_addr <= host.wdata;
            end
        end
    end

    // Bank 0 starts at 2 MB, each bank is 128 KB
    assign page = PAGE_W'(`QSPI_BANK_BASE) + PAGE_W'(bank_reg);

    // Request stays up until the sequencer sees it on a step
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (wr_addr) begin
            pending <= 1'b1;            // New write wins over a same-cycle accept
        end else if (accept) begin
            pending <= 1'b0;
        end
    end

    assign req.pending = pending;
    assign req.addr    = {page, word_addr, 1'b0};   // Even byte address

    // Valid drops when a new read is asked for
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (wr_addr) begin
            valid <= 1'b0;
        end else if (done_pulse) begin
            valid <= 1'b1;              // Stays up until the next address write
        end
    end

    // Read-back mux
    always_comb begin
        rdata = '0;                     // Quiet bus when not selected
        if (rd_en) begin
            case (host.offset)
                REG_DATA: begin
                    rdata = data_word;
                end
                REG_STATUS: begin
                    rdata = {{(`ROM_DATA_W-1){1'b0}}, valid};
                end
                default: begin
                    rdata = '1;         // Write-only and unmapped offsets
                end
            endcase
        end
    end

endmodule

//--- hw/qspi_read_fsm.sv
`include "rom_ctrl_macros.svh"

module qspi_read_fsm (
    input  logic                    clk,
    input  logic                    reset,
    input  rom_ctrl_pkg::read_req_t req,
    output logic                    accept,      // Request taken this clock
    output logic                    done_pulse,  // One clock at the done step
    output rom_ctrl_pkg::seq_step_t step,
    output logic                    cs_n,
    output logic                    sck
);

    import rom_ctrl_pkg::*;

    localparam int DUMMY_W = $clog2(`QSPI_DUMMY_CYCLES);

    logic               div;            // SPI clock at half rate
    logic               tick;           // Step enable
    seq_state_t         state;
    logic [2:0]         bit_cnt;        // Bit or nibble index in the phase
    logic [DUMMY_W-1:0] dummy_cnt;

    // Divider toggles every clk
    always_ff @(posedge clk) begin
        if (reset) begin
            div <= 1'b0;
        end else begin
            div <= ~div;
        end
    end

    // Steps land where sck falls, so the flash sees stable data on its rising edge
    assign tick = div;

    assign accept = tick && (state == ST_IDLE) && req.pending;

    // Transaction sequencer
    // One SPI cycle per state visit, cs_n and done_pulse registered with the state
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            bit_cnt    <= '0;
            dummy_cnt  <= '0;
            cs_n       <= 1'b1;
            done_pulse <= 1'b0;
        end else begin
            done_pulse <= 1'b0;
            if (tick) begin
                case (state)
                    ST_IDLE: begin
                        if (req.pending) begin
                            state   <= ST_CMD;  // Cycle 0 starts here
                            cs_n    <= 1'b0;
                            bit_cnt <= '0;
                        end
                    end
                    ST_CMD: begin
                        if (bit_cnt == 3'(`QSPI_CMD_CYCLES - 1)) begin
                            state   <= ST_ADDR;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                    ST_ADDR: begin
                        if (bit_cnt == 3'(`QSPI_ADDR_CYCLES - 1)) begin
                            state   <= ST_MODE;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                    ST_MODE: begin
                        if (bit_cnt == 3'(`QSPI_MODE_CYCLES - 1)) begin
                            state     <= ST_DUMMY;
                            dummy_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                    ST_DUMMY: begin
                        // Last dummy cycle already carries nibble 0
                        if (dummy_cnt == DUMMY_W'(`QSPI_DUMMY_CYCLES - 1)) begin
                            state   <= ST_READ;
                            bit_cnt <= 3'd1;    // Read index is the nibble number
                        end else begin
                            dummy_cnt <= dummy_cnt + 1'b1;
                        end
                    end
                    ST_READ: begin
                        if (bit_cnt == 3'(`QSPI_DATA_NIBBLES - 1)) begin
                            state      <= ST_DONE;
                            cs_n       <= 1'b1;     // Cycle 23 with the flash deselected
                            done_pulse <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                    ST_DONE: begin
                        state <= ST_IDLE;           // Gives the flash its cs_n high time
                    end
                    default: begin
                        state <= ST_IDLE;
                        cs_n  <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Clock runs only while the flash is selected
    assign sck = div & ~cs_n;

    // Per-step view for the datapath
    assign step.step  = tick;
    assign step.state = state;
    assign step.index = (state == ST_DUMMY) ? 3'(dummy_cnt) : bit_cnt;

endmodule

//--- hw/qspi_datapath.sv
`include "rom_ctrl_macros.svh"

module qspi_datapath (
    input  logic                    clk,
    input  logic                    reset,
    input  rom_ctrl_pkg::seq_step_t step,
    input  logic [`QSPI_ADDR_W-1:0] flash_addr,
    input  logic [3:0]              dq_in,
    output logic [3:0]              dq_out,
    output logic [3:0]              dq_oe,
    output logic [`ROM_DATA_W-1:0]  data_word
);

    import rom_ctrl_pkg::*;

    // Address nibbles followed by the mode byte go out on all four lines
    localparam int QUAD_W    = `QSPI_ADDR_W + 8;
    localparam int NIB_SEL_W = $clog2(`QSPI_DATA_NIBBLES);

    logic [7:0]           cmd_sr;       // Command bits, MSB first
    logic [QUAD_W-1:0]    quad_sr;      // Address and mode, high nibble first
    logic                 quad_phase;
    logic                 last_dummy;
    logic                 sample_en;
    logic [NIB_SEL_W-1:0] nib_sel;

    assign quad_phase = (step.state == ST_ADDR) || (step.state == ST_MODE);
    assign last_dummy = (step.state == ST_DUMMY) &&
                        (step.index == 3'(`QSPI_DUMMY_CYCLES - 1));

    // Shift registers
    // Reloaded every clk while idle, so the idle-to-command step
    // captures the address that goes with the request being accepted
    always_ff @(posedge clk) begin
        if (step.state == ST_IDLE) begin
            cmd_sr  <= `QSPI_CMD_QUAD_READ;
            quad_sr <= {flash_addr, `QSPI_MODE_BYTE};
        end else if (step.step) begin
            if (step.state == ST_CMD) begin
                cmd_sr <= {cmd_sr[6:0], 1'b0};          // Next bit for the next cycle
            end
            if (quad_phase) begin
                quad_sr <= {quad_sr[QUAD_W-5:0], 4'h0}; // Next nibble
            end
        end
    end

    // Pin drive follows the phase
    // State and shifters only move on step edges, so the pins do too
    always_comb begin
        dq_out = 4'h0;
        dq_oe  = 4'h0;                              // Released outside the write phases
        case (step.state)
            ST_CMD: begin
                dq_out = {3'b000, cmd_sr[7]};
                dq_oe  = 4'b0001;                   // Single line for the command
            end
            ST_ADDR, ST_MODE: begin
                dq_out = quad_sr[QUAD_W-1 -: 4];
                dq_oe  = 4'b1111;
            end
            default: begin
                dq_out = 4'h0;
                dq_oe  = 4'h0;
            end
        endcase
    end

    // Input capture
    // The low half of a cycle is the clk with no step
    // The flash has driven the nibble since the falling sck edge
    assign sample_en = !step.step && (last_dummy || (step.state == ST_READ));

    // Nibble 0 comes in the last dummy cycle, then the read index
    assign nib_sel = (step.state == ST_READ) ? step.index[NIB_SEL_W-1:0] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            data_word <= '0;                        // Data register reads zero before any read
        end else if (sample_en) begin
            data_word[nib_sel*4 +: 4] <= dq_in;     // Low nibble first
        end
    end

endmodule

//--- hw/rom_controller.sv
`include "rom_ctrl_macros.svh"

module rom_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  rom_ctrl_pkg::host_bus_t host,
    output logic [`ROM_DATA_W-1:0]  rdata,
    output logic                    cs_n,
    output logic                    sck,
    output logic [3:0]              dq_out,      // Pad buffers live in the board wrapper
    output logic [3:0]              dq_oe,
    input  logic [3:0]              dq_in
);

    import rom_ctrl_pkg::*;

    read_req_t              req;            // Registers to sequencer
    logic                   accept;
    logic                   done_pulse;
    seq_step_t              step;           // Sequencer to datapath
    logic [`ROM_DATA_W-1:0] data_word;      // Datapath to registers

    rom_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .host       (host),
        .rdata      (rdata),
        .req        (req),
        .accept     (accept),
        .done_pulse (done_pulse),
        .data_word  (data_word)
    );

    qspi_read_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .accept     (accept),
        .done_pulse (done_pulse),
        .step       (step),
        .cs_n       (cs_n),
        .sck        (sck)
    );

    qspi_datapath u_datapath (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .flash_addr (req.addr),
        .dq_in      (dq_in),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe),
        .data_word  (data_word)
    );

endmodule

//--- testbench/qspi_flash_model.sv
module qspi_flash_model (
    input  logic       cs_n,
    input  logic       sck,
    input  logic [3:0] dq_out,
    input  logic [3:0] dq_oe,
    output logic [3:0] dq_in
);

    timeunit 1ns;
    timeprecision 100ps;

    int          cycle;             // SPI cycles seen in this transaction
    logic [7:0]  cmd_sr;
    logic [23:0] addr_sr;
    logic [7:0]  mode_sr;
    logic [15:0] word;              // Word returned for the decoded address
    logic [7:0]  last_cmd;
    logic [23:0] last_addr;
    logic [7:0]  last_mode;
    int          reads_seen;
    logic        contention;        // Sticky, host drove while the flash owns the bus
    logic        wide_cmd_oe;       // Sticky, DQ1 to DQ3 enabled in the command phase

    // Content rule: inverted low half plus the bank field
    function automatic logic [15:0] pattern_word(input logic [23:0] addr);
        return ~addr[15:0] + 16'(addr[20:17]);
    endfunction

    initial begin
        dq_in       = 4'h0;
        word        = '0;
        last_cmd    = '0;
        last_addr   = '0;
        last_mode   = '0;
        reads_seen  = 0;
        contention  = 1'b0;
        wide_cmd_oe = 1'b0;
    end

    // Decode on rising sck, deselect restarts the count
    always @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            cycle = 0;
        end else begin
            if (cycle < 8) begin
                cmd_sr = {cmd_sr[6:0], dq_out[0]};      // MSB first on DQ0
                if (dq_oe[3:1] != 3'b000) begin
                    wide_cmd_oe = 1'b1;
                end
            end else if (cycle < 14) begin
                addr_sr = {addr_sr[19:0], dq_out};      // High nibble first
            end else if (cycle < 16) begin
                mode_sr = {mode_sr[3:0], dq_out};
            end else if (cycle < 23 && dq_oe != 4'h0) begin
                contention = 1'b1;                      // Dummy and data cycles
            end
            if (cycle == 15) begin
                last_cmd  = cmd_sr;
                last_addr = addr_sr;
                last_mode = mode_sr;
                word      = pattern_word(addr_sr);
                reads_seen++;
            end
            cycle++;
        end
    end

    // Nibble k goes out on the falling edge that starts cycle 19+k
    always @(negedge sck) begin
        if (cycle >= 19 && cycle <= 22) begin
            dq_in = word[(cycle-19)*4 +: 4];            // Bits 3:0 first
        end else begin
            dq_in = 4'h0;                               // Released
        end
    end

endmodule

//--- testbench/tb_rom_controller.sv
`include "rom_ctrl_macros.svh"

module tb_rom_controller;

    timeunit 1ns;
    timeprecision 100ps;

    import rom_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RANDOM_READS = 40;
    localparam int NUM_READS    = RANDOM_READS + 3;     // Tests 2, 4 and 5 add one each
    localparam int POLL_LIMIT   = 32;                   // Two clk per poll, above 52 clk

    logic                   clk;
    logic                   reset;
    host_bus_t              host;
    logic [`ROM_DATA_W-1:0] rdata;
    logic                   cs_n;
    logic                   sck;
    logic [3:0]             dq_out;
    logic [3:0]             dq_oe;
    logic [3:0]             dq_in;
    logic [31:0]            lfsr;
    int                     errors;
    int                     test_errors;
    int                     tests_run;
    int                     tests_failed;

    rom_controller dut0 (
        .clk    (clk),
        .reset  (reset),
        .host   (host),
        .rdata  (rdata),
        .cs_n   (cs_n),
        .sck    (sck),
        .dq_out (dq_out),
        .dq_oe  (dq_oe),
        .dq_in  (dq_in)
    );

    qspi_flash_model flash0 (
        .cs_n   (cs_n),
        .sck    (sck),
        .dq_out (dq_out),
        .dq_oe  (dq_oe),
        .dq_in  (dq_in)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};     // One step per bit
        end
    endtask

    // Bank 0 sits at 2 MB, banks are 128 KB, word addresses are doubled
    function automatic logic [23:0] expected_addr(input logic [3:0] bank,
                                                  input logic [15:0] word);
        return 24'h20_0000 + 24'(bank) * 24'h2_0000 + 24'(word) * 24'd2;
    endfunction

    function automatic logic [15:0] expected_data(input logic [3:0] bank,
                                                  input logic [15:0] word);
        logic [23:0] addr;
        addr = expected_addr(bank, word);
        return ~addr[15:0] + 16'(bank);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic bus_write(input logic [3:0] offset, input logic [15:0] data);
        @(negedge clk);
        host.select = 1'b1;
        host.write  = 1'b1;
        host.offset = offset;
        host.wdata  = data;
        @(negedge clk);
        host = '0;
    endtask

    // Sampled at the following falling edge, rdata settled by then
    task automatic bus_read(input logic [3:0] offset, input logic sel,
                            output logic [15:0] data);
        @(negedge clk);
        host.select = sel;
        host.read   = 1'b1;
        host.offset = offset;
        @(negedge clk);
        data = rdata;
        host = '0;
    endtask

    task automatic wait_valid();
        logic [15:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (st[0] !== 1'b1 && polls < POLL_LIMIT) begin
            bus_read(REG_STATUS, 1'b1, st);
            polls++;
        end
        assert (st[0] === 1'b1) else begin
            $display("Status valid did not rise within %0d polls after an address write",
                     POLL_LIMIT);
            test_errors++;
        end
    endtask

    // Address write, poll, data read, then compare what the flash decoded
    task automatic run_read(input logic [3:0] bank, input logic [15:0] word);
        logic [15:0] st;
        logic [15:0] data;
        int          seen;
        seen = flash0.reads_seen;
        bus_write(REG_ADDR, word);
        bus_read(REG_STATUS, 1'b1, st);
        check_value("status before done", st, 32'h0);
        wait_valid();
        bus_read(REG_DATA, 1'b1, data);
        check_value("flash command", flash0.last_cmd, 32'hEB);
        check_value("flash address", flash0.last_addr, expected_addr(bank, word));
        check_value("flash mode", flash0.last_mode, 32'hF0);
        check_value("transactions seen", flash0.reads_seen, seen + 1);
        check_value("read data", data, expected_data(bank, word));
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            $display("Test %0d %s: FAIL, %0d errors", tests_run, name, test_errors);
            tests_failed++;
        end
        errors      += test_errors;
        test_errors = 0;
    endtask

    initial begin
        logic [31:0] r;
        logic [3:0]  bank;
        logic [15:0] word;
        logic [15:0] st;
        host         = '0;
        reset        = 1'b1;
        lfsr         = 32'ha079_5bd5;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Idle bus after reset
        check_value("cs_n", cs_n, 32'h1);
        check_value("sck", sck, 32'h0);
        check_value("dq_oe", dq_oe, 32'h0);
        bus_read(REG_STATUS, 1'b1, st);
        check_value("status after reset", st, 32'h0);
        finish_test("reset state");

        bus_write(REG_BANK, 16'h0000);
        take_bits(16, r);
        run_read(4'h0, r[15:0]);
        finish_test("single read in bank 0");

        for (int i = 0; i < RANDOM_READS; i++) begin
            take_bits(4, r);
            bank = r[3:0];
            take_bits(16, r);
            word = r[15:0];
            bus_write(REG_BANK, {12'h000, bank});
            run_read(bank, word);
        end
        finish_test("random reads");

        // Bank write must not open a transaction
        take_bits(4, r);
        bank = r[3:0];
        bus_write(REG_BANK, {12'h000, bank});
        repeat (40) begin
            @(negedge clk);
            check_value("cs_n after bank write", cs_n, 32'h1);
        end
        bus_read(REG_STATUS, 1'b1, st);
        check_value("status after bank write", st, 32'h1);    // Earlier read still valid
        take_bits(16, r);
        run_read(bank, r[15:0]);
        finish_test("bank write alone");

        bus_read(REG_ADDR, 1'b1, st);
        check_value("address register read", st, 32'hFFFF);
        bus_read(REG_BANK, 1'b1, st);
        check_value("bank register read", st, 32'hFFFF);
        bus_read(4'h7, 1'b1, st);
        check_value("unmapped offset 7 read", st, 32'hFFFF);
        take_bits(3, r);
        bus_read({1'b1, r[2:0]}, 1'b1, st);
        check_value("unmapped high offset read", st, 32'hFFFF);
        bus_read(REG_DATA, 1'b0, st);
        check_value("unselected data read", st, 32'h0);
        bus_read(REG_STATUS, 1'b0, st);
        check_value("unselected status read", st, 32'h0);
        take_bits(16, r);
        run_read(bank, r[15:0]);                              // Status zero until done
        finish_test("register read-back");

        check_value("bus contention", flash0.contention, 32'h0);
        check_value("wide command enable", flash0.wide_cmd_oe, 32'h0);
        check_value("total transactions", flash0.reads_seen, NUM_READS);
        finish_test("bus direction");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog sized from the number of reads
    initial begin
        #(CLK_PERIOD * (60 * NUM_READS + 600));
        $display("Timeout: the tests did not finish before the watchdog expired");
        $display("Test failures found");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/rom_ctrl_pkg.sv
hw/rom_regs.sv
hw/qspi_read_fsm.sv
hw/qspi_datapath.sv
hw/rom_controller.sv
testbench/qspi_flash_model.sv
testbench/tb_rom_controller.sv
